// ==== Makefile ====
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module coreTb \
		-Mdir obj_dir -o coreSim

run: build
	./obj_dir/coreSim | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module coreTb
	verilator --lint-only -Wall -f sources.f --top-module pipelineCore

clean:
	rm -rf obj_dir $(LOG)

// ==== source/cpuDefines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////
`define CPU_WORD_W     16  // Data and instruction word
`define CPU_REG_IDX_W  4   // Selects one of 16 registers
`define CPU_OPCODE_W   4   // Opcode field
`define CPU_IMM8_W     8   // LLB/LHB byte immediate

`define CPU_RESET_PC   16'h0000  // First fetch address
`define CPU_PC_STEP    16'd2     // Byte addressed, one word per instruction

//////////////////////////////////////////////////
// Instruction field positions, low bit of each
//////////////////////////////////////////////////
`define CPU_OPCODE_LSB 12  // Bits 15..12
`define CPU_RD_LSB     8   // Bits 11..8
`define CPU_RS_LSB     4   // Bits 7..4
`define CPU_RT_LSB     0   // Bits 3..0, also the shift amount
`define CPU_IMM8_LSB   0   // Bits 7..0

`endif

// ==== source/cpuPkg.sv ====
`default_nettype none

`include "cpuDefines.svh"

package cpuPkg;

  typedef logic [`CPU_WORD_W-1:0]    wordT;    // Register value, result or pc
  typedef logic [`CPU_REG_IDX_W-1:0] regIdxT;  // Register number

  // Opcodes kept by this core; the rest decode as no-ops
  typedef enum logic [`CPU_OPCODE_W-1:0] {
    opAdd = 4'd0,   // Wrapping add
    opSub = 4'd1,   // Wrapping subtract
    opXor = 4'd2,   // Bitwise xor
    opSll = 4'd4,   // Logical shift left
    opSra = 4'd5,   // Arithmetic shift right
    opLlb = 4'd10,  // Load low byte
    opLhb = 4'd11,  // Load high byte
    opHlt = 4'd15   // Stop fetching
  } opcodeE;

  // ALU operand source
  typedef enum logic {
    fwdReg = 1'b0,  // Value read in decode
    fwdEx  = 1'b1   // Result sitting in EX/WB
  } fwdSelE;

  // ID/EX pipeline register contents
  typedef struct packed {
    logic                   valid;     // Slot holds a fetched instruction
    opcodeE                 opcode;    // ALU operation
    regIdxT                 rs;        // Operand A register (rd for LLB/LHB)
    regIdxT                 rt;        // Operand B register or shift amount
    regIdxT                 rd;        // Destination
    wordT                   opA;       // Operand A as read in decode
    wordT                   opB;       // Operand B as read in decode
    logic [`CPU_IMM8_W-1:0] imm;       // Byte immediate
    logic                   regWrite;  // Writes rd at write-back
    logic                   isHalt;    // HLT in flight
  } idExT;

  // EX/WB pipeline register contents
  typedef struct packed {
    logic   valid;     // Slot holds an executed instruction
    regIdxT rd;        // Destination
    wordT   result;    // ALU result
    logic   regWrite;  // Register file write request
    logic   isHalt;    // HLT reached write-back
  } exWbT;

endpackage

`default_nettype wire

// ==== source/decodeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuDefines.svh"

module decodeStage
  import cpuPkg::*;
(
  input  logic   clk,         // System clock
  input  logic   reset,       // Sync reset, active high
  input  wordT   instr,       // Instruction word from IF/ID
  input  logic   fetchValid,  // IF/ID slot is occupied
  input  logic   wbEn,        // Register file write strobe
  input  regIdxT wbReg,       // Register being written
  input  wordT   wbData,      // Value being written
  output idExT   decoded      // Next ID/EX contents
);

  localparam int regCount = 1 << `CPU_REG_IDX_W;  // 16 registers

  wordT   regFile [0:regCount-1];  // General purpose registers
  opcodeE opcode;                  // Opcode field as enum
  regIdxT rdIdx;                   // Destination field
  regIdxT rsIdx;                   // Operand A register
  regIdxT rtIdx;                   // Operand B register or shift amount
  logic   isByteLoad;              // LLB or LHB, rd is also the source
  logic   writesReg;               // Opcode produces a register result
  logic   rsBypass;                // Write-back hits operand A this cycle
  logic   rtBypass;                // Write-back hits operand B this cycle
  wordT   opA;                     // Operand A after bypass
  wordT   opB;                     // Operand B after bypass

  //////////////////////////////////////////////////
  // Field split
  //////////////////////////////////////////////////
  assign opcode = opcodeE'(instr[`CPU_OPCODE_LSB +: `CPU_OPCODE_W]);
  assign rdIdx  = instr[`CPU_RD_LSB +: `CPU_REG_IDX_W];
  assign rtIdx  = instr[`CPU_RT_LSB +: `CPU_REG_IDX_W];

  assign isByteLoad = (opcode == opLlb) || (opcode == opLhb);
  assign rsIdx      = isByteLoad ? rdIdx : instr[`CPU_RS_LSB +: `CPU_REG_IDX_W];  // Keep other byte

  // Only the kept ALU ops write back
  always_comb begin
    case (opcode)
      opAdd, opSub, opXor, opSll, opSra, opLlb, opLhb: writesReg = 1'b1;
      default:                                         writesReg = 1'b0;  // HLT and unused codes
    endcase
  end

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < regCount; i++) begin
        regFile[i] <= '0;  // All registers start at zero
      end
    end else if (wbEn) begin
      regFile[wbReg] <= wbData;  // Write from EX/WB
    end
  end

  // Same-cycle write shows up on the read port
  assign rsBypass = wbEn && (wbReg == rsIdx);
  assign rtBypass = wbEn && (wbReg == rtIdx);
  assign opA      = rsBypass ? wbData : regFile[rsIdx];
  assign opB      = rtBypass ? wbData : regFile[rtIdx];

  //////////////////////////////////////////////////
  // ID/EX bundle
  //////////////////////////////////////////////////
  always_comb begin
    decoded.valid    = fetchValid;
    decoded.opcode   = opcode;
    decoded.rs       = rsIdx;
    decoded.rt       = rtIdx;
    decoded.rd       = rdIdx;
    decoded.opA      = opA;
    decoded.opB      = opB;
    decoded.imm      = instr[`CPU_IMM8_LSB +: `CPU_IMM8_W];
    decoded.regWrite = fetchValid && writesReg;        // Bubbles never write
    decoded.isHalt   = fetchValid && (opcode == opHlt);  // Real HLT only
  end

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuDefines.svh"

module executeStage
  import cpuPkg::*;
(
  input  idExT   idEx,      // ID/EX register contents
  input  fwdSelE fwdA,      // Operand A source
  input  fwdSelE fwdB,      // Operand B source
  input  wordT   wbResult,  // Result held in EX/WB
  output wordT   result     // ALU output toward EX/WB
);

  wordT                    aluA;   // Operand A after forwarding
  wordT                    aluB;   // Operand B after forwarding
  logic [`CPU_REG_IDX_W-1:0] shamt;  // Shift amount from the rt field

  //////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////
  assign aluA  = (fwdA == fwdEx) ? wbResult : idEx.opA;
  assign aluB  = (fwdB == fwdEx) ? wbResult : idEx.opB;
  assign shamt = idEx.rt;  // Shifts take the field, not a register

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  always_comb begin
    case (idEx.opcode)
      opAdd: begin
        result = aluA + aluB;  // Wraps at 16 bits
      end
      opSub: begin
        result = aluA - aluB;  // Wraps at 16 bits
      end
      opXor: begin
        result = aluA ^ aluB;
      end
      opSll: begin
        result = aluA << shamt;  // Zero fill
      end
      opSra: begin
        result = wordT'($signed(aluA) >>> shamt);  // Sign fill
      end
      opLlb: begin
        result = {aluA[`CPU_WORD_W-1:`CPU_IMM8_W], idEx.imm};  // Low byte replaced
      end
      opLhb: begin
        result = {idEx.imm, aluA[`CPU_IMM8_W-1:0]};  // High byte replaced
      end
      default: begin
        result = '0;  // HLT and no-ops, never written back
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/forwardingUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module forwardingUnit
  import cpuPkg::*;
(
  input  regIdxT exRs,        // Operand A register of the op in execute
  input  regIdxT exRt,        // Operand B register of the op in execute
  input  regIdxT wbRd,        // Destination held in EX/WB
  input  logic   wbRegWrite,  // EX/WB op writes a register
  input  logic   wbValid,     // EX/WB slot is occupied
  output fwdSelE fwdA,        // Source for operand A
  output fwdSelE fwdB         // Source for operand B
);

  // Older op still in EX/WB owns the newest copy of src
  function automatic fwdSelE pickSource(
    input regIdxT src,
    input regIdxT dst,
    input logic   dstWrites
  );
    fwdSelE sel;
    sel = fwdReg;  // Decode value by default
    if (dstWrites && (dst == src)) begin
      sel = fwdEx;  // Result not yet in the register file
    end
    return sel;
  endfunction

  logic wbWrites;  // Live register write in EX/WB

  assign wbWrites = wbValid && wbRegWrite;

  always_comb begin
    fwdA = pickSource(exRs, wbRd, wbWrites);
    fwdB = pickSource(exRt, wbRd, wbWrites);
  end

  // Two-ahead hazards resolve through the decode bypass instead

endmodule

`default_nettype wire

// ==== source/pipelineCore.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuDefines.svh"

module pipelineCore
  import cpuPkg::*;
(
  input  logic   clk,      // System clock
  input  logic   reset,    // Sync reset, active high

  // Instruction port, served combinationally
  input  wordT   instr,    // Word at pc
  output wordT   pc,       // Fetch address

  // Write-back port
  output logic   wbValid,  // One-cycle result strobe
  output regIdxT wbReg,    // Register written
  output wordT   wbData,   // Value written

  output logic   hlt       // HLT reached write-back, sticky
);

  wordT   ifInstr;       // IF/ID instruction word
  logic   fetchValid;    // IF/ID slot occupied
  logic   fetchStopped;  // HLT already decoded
  logic   freeze;        // Stop pc and fetch from the next edge
  idExT   decoded;       // Decode output
  idExT   idEx;          // ID/EX register
  exWbT   exWbNext;      // Execute output, packed
  exWbT   exWb;          // EX/WB register
  fwdSelE fwdA;          // Operand A source
  fwdSelE fwdB;          // Operand B source
  wordT   aluResult;     // Execute result
  logic   wbEn;          // Register file write this cycle
  logic   hltHold;       // Keeps hlt up after the HLT slot drains

  //////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////
  assign freeze = decoded.isHalt || fetchStopped;  // HLT in decode or earlier

  always_ff @(posedge clk) begin
    if (reset) begin
      pc           <= `CPU_RESET_PC;
      fetchValid   <= 1'b0;
      fetchStopped <= 1'b0;
    end else begin
      fetchStopped <= freeze;
      fetchValid   <= !freeze;  // Word after HLT is dropped
      if (!freeze) begin
        pc <= pc + `CPU_PC_STEP;
      end
    end
  end

  always_ff @(posedge clk) begin
    ifInstr <= instr;  // Qualified by fetchValid
  end

  //////////////////////////////////////////////////
  // Decode and ID/EX
  //////////////////////////////////////////////////
  decodeStage iDecode (
    .clk       (clk),
    .reset     (reset),
    .instr     (ifInstr),
    .fetchValid(fetchValid),
    .wbEn      (wbEn),
    .wbReg     (exWb.rd),
    .wbData    (exWb.result),
    .decoded   (decoded)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      idEx <= '0;  // Empty slot
    end else begin
      idEx <= decoded;
    end
  end

  //////////////////////////////////////////////////
  // Execute and EX/WB
  //////////////////////////////////////////////////
  forwardingUnit iForward (
    .exRs      (idEx.rs),
    .exRt      (idEx.rt),
    .wbRd      (exWb.rd),
    .wbRegWrite(exWb.regWrite),
    .wbValid   (exWb.valid),
    .fwdA      (fwdA),
    .fwdB      (fwdB)
  );

  executeStage iExecute (
    .idEx    (idEx),
    .fwdA    (fwdA),
    .fwdB    (fwdB),
    .wbResult(exWb.result),
    .result  (aluResult)
  );

  always_comb begin
    exWbNext.valid    = idEx.valid;
    exWbNext.rd       = idEx.rd;
    exWbNext.result   = aluResult;
    exWbNext.regWrite = idEx.regWrite;
    exWbNext.isHalt   = idEx.isHalt;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      exWb <= '0;
    end else begin
      exWb <= exWbNext;
    end
  end

  //////////////////////////////////////////////////
  // Write-back and halt
  //////////////////////////////////////////////////
  assign wbEn    = exWb.valid && exWb.regWrite;  // HLT never sets regWrite
  assign wbValid = wbEn;
  assign wbReg   = exWb.rd;
  assign wbData  = exWb.result;

  assign hlt = (exWb.valid && exWb.isHalt) || hltHold;

  always_ff @(posedge clk) begin
    if (reset) begin
      hltHold <= 1'b0;
    end else begin
      hltHold <= hlt;  // Held until reset
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/cpuPkg.sv
source/decodeStage.sv
source/forwardingUnit.sv
source/executeStage.sv
source/pipelineCore.sv
verification/coreChecker.sv
verification/coreTb.sv

// ==== verification/coreChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuDefines.svh"

module coreChecker
  import cpuPkg::*;
#(
  parameter int maxExp = 32  // Capacity of the expected list
) (
  input  logic   clk,                      // Same clock as the DUT
  input  logic   reset,                    // DUT reset
  input  wordT   pc,                       // Fetch address
  input  logic   wbValid,                  // Write-back strobe
  input  regIdxT wbReg,                    // Register written
  input  wordT   wbData,                   // Value written
  input  logic   hlt,                      // Halt flag
  input  regIdxT expReg  [0:maxExp-1],     // Expected registers in program order
  input  wordT   expData [0:maxExp-1],     // Expected values in program order
  input  int     expCount,                 // Entries used in the list
  input  wordT   expHaltPc,                // pc held once the core has halted
  output int     valueErrors,              // Wrong values seen
  output int     otherErrors               // Protocol problems seen
);

  int   valueCount = 0;     // Running count of wrong values
  int   otherCount = 0;     // Running count of other failures
  int   eventCount = 0;     // Write-backs consumed so far
  logic hltSeen    = 1'b0;  // hlt has been high once

  assign valueErrors = valueCount;
  assign otherErrors = otherCount;

  task automatic reportMismatch(input string name, input wordT got, input wordT exp);
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    valueCount++;
  endtask

  task automatic reportProblem(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    otherCount++;
  endtask

  //////////////////////////////////////////////////
  // Sampled on the falling edge where outputs are settled
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (reset) begin
      if (pc !== `CPU_RESET_PC) reportMismatch("pc", pc, `CPU_RESET_PC);  // Reset values
      if (wbValid !== 1'b0) reportMismatch("wbValid", wordT'(wbValid), '0);
      if (hlt !== 1'b0) reportMismatch("hlt", wordT'(hlt), '0);
    end else begin
      if (hltSeen && (hlt !== 1'b1)) begin
        reportProblem("hlt fell after it had risen");  // Must be sticky
      end
      if ((hltSeen || (hlt === 1'b1)) && (pc !== expHaltPc)) begin
        reportMismatch("pc", pc, expHaltPc);  // Frozen one word past HLT
      end
      if (wbValid === 1'b1) begin
        if (hltSeen || hlt) begin
          reportProblem("write-back seen after hlt");
        end else if (eventCount >= expCount) begin
          reportProblem("more write-backs than the expected list holds");
        end else begin
          if (wbReg !== expReg[eventCount]) begin
            reportMismatch("wbReg", wordT'(wbReg), wordT'(expReg[eventCount]));
          end
          if (wbData !== expData[eventCount]) begin
            reportMismatch("wbData", wbData, expData[eventCount]);
          end
        end
        eventCount++;
      end else if (wbValid !== 1'b0) begin
        reportProblem("wbValid is unknown");
      end
      if ((hlt === 1'b1) && !hltSeen) begin
        hltSeen = 1'b1;
        if (eventCount != expCount) begin
          reportProblem($sformatf("%0d write-backs before hlt but %0d expected",
                                  eventCount, expCount));  // All results precede hlt
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/coreTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuDefines.svh"

module coreTb
  import cpuPkg::*;
();

  localparam int   maxExp    = 32;        // Expected list capacity
  localparam int   maxCycles = 100;       // Limit for the halt wait
  localparam wordT haltWord  = 16'hF000;  // HLT word, also served past the table

  logic   clk;
  logic   reset;
  wordT   instr;
  wordT   pc;
  logic   wbValid;
  regIdxT wbReg;
  wordT   wbData;
  logic   hlt;

  wordT   progWords  [$];          // Instruction words of the program
  string  progLabels [$];          // Row labels of the program
  int     randRows   [$];          // Rows whose rs field gets a random value
  regIdxT expReg  [0:maxExp-1];    // Expected registers from the reference model
  wordT   expData [0:maxExp-1];    // Expected values from the reference model
  int     expCount;
  wordT   expHaltPc;               // Fetch address where the core parks
  int     valueErrors;
  int     otherErrors;
  int     tbErrors;
  int     cycles;

  pipelineCore dut0 (
    .clk    (clk),
    .reset  (reset),
    .instr  (instr),
    .pc     (pc),
    .wbValid(wbValid),
    .wbReg  (wbReg),
    .wbData (wbData),
    .hlt    (hlt)
  );

  coreChecker #(.maxExp(maxExp)) check0 (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .wbValid    (wbValid),
    .wbReg      (wbReg),
    .wbData     (wbData),
    .hlt        (hlt),
    .expReg     (expReg),
    .expData    (expData),
    .expCount   (expCount),
    .expHaltPc  (expHaltPc),
    .valueErrors(valueErrors),
    .otherErrors(otherErrors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  function automatic wordT fetchWord(input wordT addr);
    int idx;
    idx = int'(addr / `CPU_PC_STEP);  // Byte address to row
    if (idx < progWords.size()) return progWords[idx];
    return haltWord;  // Past the end
  endfunction

  // Instruction port refreshed on the falling edge
  always @(negedge clk) begin
    instr <= fetchWord(pc);
  end

  task automatic addRow(input wordT word, input string label, input bit randomSrc);
    if (randomSrc) randRows.push_back(progWords.size());
    progWords.push_back(word);
    progLabels.push_back(label);
  endtask

  task automatic randomizeSources();
    logic [31:0] rnd;
    wordT        w;
    foreach (randRows[i]) begin
      rnd = $urandom;
      w   = progWords[randRows[i]];
      w[`CPU_RS_LSB +: `CPU_REG_IDX_W] = rnd[`CPU_REG_IDX_W-1:0];
      progWords[randRows[i]] = w;
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model in program order without a pipeline
  //////////////////////////////////////////////////
  task automatic buildExpected();
    wordT   regs [0:15];
    wordT   w;
    wordT   a;
    wordT   b;
    wordT   res;
    opcodeE op;
    regIdxT rd;
    regIdxT rs;
    regIdxT rt;
    logic   writes;
    expCount  = 0;
    expHaltPc = wordT'((progWords.size() + 1) * `CPU_PC_STEP);  // HLT served past the end
    for (int r = 0; r < 16; r++) regs[r] = '0;
    for (int i = 0; i < maxExp; i++) begin
      expReg[i]  = '0;
      expData[i] = '0;
    end
    for (int i = 0; i < progWords.size(); i++) begin
      w  = progWords[i];
      op = opcodeE'(w[15:12]);
      rd = w[11:8];
      rs = w[7:4];
      rt = w[3:0];
      if (op == opHlt) begin
        expHaltPc = wordT'((i + 1) * `CPU_PC_STEP);  // Fetch stops one word past HLT
        break;  // Nothing after HLT runs
      end
      a      = regs[rs];
      b      = regs[rt];
      writes = 1'b1;
      case (op)
        opAdd: res = a + b;
        opSub: res = a - b;
        opXor: res = a ^ b;
        opSll: res = a << rt;
        opSra: begin
          res = a >> rt;
          if (a[15]) res = res | ~(16'hFFFF >> rt);  // Copy the sign into vacated bits
        end
        opLlb: res = {regs[rd][15:8], w[7:0]};
        opLhb: res = {w[7:0], regs[rd][7:0]};
        default: writes = 1'b0;  // Unused codes
      endcase
      if (writes) begin
        regs[rd]          = res;
        expReg[expCount]  = rd;
        expData[expCount] = res;
        $display("Row %0d %s: r%0d = %h", i, progLabels[i], rd, res);
        expCount++;
      end
    end
  endtask

  initial begin
    reset    = 1'b1;
    instr    = haltWord;
    tbErrors = 0;
    void'($urandom(22));  // One seed for the run
    addRow(16'hA134, "LLB r1 low byte", 1'b0);
    addRow(16'hB112, "LHB r1 high byte", 1'b0);        // Forwarded r1
    addRow(16'hA2FF, "LLB r2", 1'b0);
    addRow(16'hB280, "LHB r2 negative", 1'b0);
    addRow(16'hA301, "LLB r3 one", 1'b0);
    addRow(16'hA4FF, "LLB r4", 1'b0);
    addRow(16'hB4FF, "LHB r4 all ones", 1'b0);
    addRow(16'h0543, "ADD wraps to zero", 1'b0);        // r4 forwarded
    addRow(16'h1653, "SUB wraps below zero", 1'b0);     // r5 forwarded
    addRow(16'h2712, "XOR independent", 1'b0);
    addRow(16'h5824, "SRA sign fill", 1'b0);
    addRow(16'h4914, "SLL by four", 1'b0);
    addRow(16'h5A13, "SRA positive", 1'b0);
    addRow(16'h0B98, "ADD two back", 1'b0);             // r9 through the bypass
    addRow(16'h0CBB, "ADD both forwarded", 1'b0);
    addRow(16'h1DCB, "SUB forward and bypass", 1'b0);
    addRow(16'h0E07, "ADD random source", 1'b1);
    addRow(16'h2F03, "XOR random source", 1'b1);
    addRow(16'h3123, "unused opcode", 1'b0);            // No write-back
    addRow(16'h418F, "SLL by fifteen", 1'b0);
    addRow(haltWord, "HLT", 1'b0);
    randomizeSources();
    buildExpected();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset <= 1'b0;
    cycles = 0;
    while ((hlt !== 1'b1) && (cycles < maxCycles)) begin
      @(negedge clk);
      cycles++;
    end
    if (hlt !== 1'b1) begin
      $display("Timeout: hlt did not rise within %0d cycles", maxCycles);
      tbErrors++;
    end else begin
      repeat (4) @(negedge clk);  // Watch the halted core a while
    end
    @(posedge clk);  // Checker counts settled
    $display("Errors: value %0d, other %0d, run %0d", valueErrors, otherErrors, tbErrors);
    if ((valueErrors + otherErrors + tbErrors) == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
